//--- dmem.f
common/dmem_pkg.sv
dcache/dcache_store.sv
verilog/mem_req_queue.sv
verilog/dmem_top.sv
tb/dmem_properties.sv
tb/dmem_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the data-memory testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module dmem_tb -f dmem.f -Mdir obj_dir -o dmem_sim

./obj_dir/dmem_sim | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"

//--- tb/dmem_tb.sv
/* dmem_tb: random and directed testbench for the data-memory subsystem,
   with a backing memory model and an architectural memory */
`default_nettype none

module dmem_tb;
    import dmem_pkg::*;

    localparam int num_mem_lines = 8192;
    localparam int cycle_limit   = 400;

    logic         clock;
    logic         reset;
    proc_access_t proc_wr;
    proc_access_t proc_rd;
    mem_fill_t    fill;
    line_data_t   rd_data;
    logic         rd_valid;
    mem_req_t     mem_req;
    logic         mem_ready;
    logic         busy;

    line_data_t   arch_mem [num_mem_lines];
    line_data_t   back_mem [num_mem_lines];
    int           pend_rd [num_mem_lines];
    logic [12:0]  fill_line [$];
    int           fill_due [$];
    logic [12:0]  miss_line [$];
    lsq_gnt_t     miss_gnt [$];
    mem_size_e    miss_size [$];
    proc_access_t last_store;
    logic         store_open;
    logic         wr_issued;
    logic         rd_hit;
    logic [15:0]  lfsr;
    int           cycle_no;
    int           checks;
    int           errors;
    int           test_checks0;
    int           test_errors0;
    string        test_name;
    line_tag_t    tag_pool [4] = '{8'h3c, 8'h5a, 8'hc3, 8'h0f};

    dmem_top DUT (
        .clock     (clock),
        .reset     (reset),
        .proc_wr   (proc_wr),
        .proc_rd   (proc_rd),
        .fill      (fill),
        .rd_data   (rd_data),
        .rd_valid  (rd_valid),
        .mem_req   (mem_req),
        .mem_ready (mem_ready),
        .busy      (busy)
    );

    bind dmem_top dmem_properties u_dmem_properties (
        .clock (clock), .reset (reset), .proc_wr (proc_wr), .proc_rd (proc_rd),
        .rd_valid (rd_valid), .mem_req (mem_req), .mem_ready (mem_ready), .busy (busy),
        .wb_req (wb_req), .wr_req (wr_req), .rd_req (rd_req)
    );

    always #5 clock = ~clock;

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
            r = {r[62:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic line_data_t read_bytes(line_data_t line, byte_off_t off, mem_size_e size);
        line_data_t r;
        r = '0;
        for (int b = 0; b < (1 << size); b++) begin
            if (int'(off) + b < 8) begin
                r[b*8 +: 8] = line[(int'(off) + b)*8 +: 8];
            end
        end
        return r;
    endfunction

    function automatic line_data_t write_bytes(line_data_t line, byte_off_t off,
                                               mem_size_e size, line_data_t data);
        for (int b = 0; b < (1 << size); b++) begin
            if (int'(off) + b < 8) begin
                line[(int'(off) + b)*8 +: 8] = data[b*8 +: 8];
            end
        end
        return line;
    endfunction

    // every line address gives its own contents
    function automatic line_data_t init_line(logic [12:0] ln);
        return {3'b101, ln, ~ln, 3'b010, ln ^ 13'h0a5f, 6'h2c, ln + 13'd77};
    endfunction

    function automatic proc_access_t random_access(input logic is_store);
        proc_access_t a;
        a = '0;
        a.en     = rand_bits(1) == 1;
        a.tag    = tag_pool[2'(rand_bits(2))];
        a.idx    = line_idx_t'(rand_bits(5));
        a.size   = mem_size_e'(rand_bits(2));
        a.offset = byte_off_t'(rand_bits(3) << a.size);
        if (is_store) begin
            a.data = read_bytes(rand_bits(64), 3'd0, a.size);
        end else begin
            a.gnt = lsq_gnt_t'(8'd1 << rand_bits(3));
        end
        return a;
    endfunction

    task automatic check_line(input string name, input line_data_t expected,
                              input line_data_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s %s: expected %h, actual %h", test_name, name,
                     expected, actual);
        end
    endtask

    task automatic check_req(input string name, input req_kind_e exp_kind,
                             input mem_addr_t exp_addr, input mem_size_e exp_size,
                             input req_kind_e act_kind, input mem_addr_t act_addr,
                             input mem_size_e act_size);
        checks++;
        if (act_kind !== exp_kind || act_addr !== exp_addr || act_size !== exp_size) begin
            errors++;
            $display("MISMATCH %s %s: expected %s %h %s, actual %s %h %s", test_name, name,
                     exp_kind.name(), exp_addr, exp_size.name(),
                     act_kind.name(), act_addr, act_size.name());
        end
    endtask

    task automatic check_gnt(input string name, input lsq_gnt_t expected, input lsq_gnt_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s %s: expected %b, actual %b", test_name, name,
                     expected, actual);
        end
    endtask

    // memory side of a handshake
    task automatic take_request();
        logic [12:0] ln;
        logic [12:0] exp_ln;
        ln = mem_req.addr[15:3];
        case (mem_req.kind)
            req_read: begin
                if (miss_line.size() == 0) begin
                    errors++;
                    $display("ERROR: read request for %h without a load miss", mem_req.addr);
                end else begin
                    exp_ln = miss_line.pop_front();
                    check_req("read_req", req_read, {exp_ln, 3'b000}, miss_size.pop_front(),
                              mem_req.kind, mem_req.addr, mem_req.size);
                    check_gnt("read_gnt", miss_gnt.pop_front(), mem_req.gnt);
                    check_line("read_memory", arch_mem[exp_ln], back_mem[exp_ln]);
                    fill_line.push_back(exp_ln);
                    fill_due.push_back(cycle_no + 2 + int'(rand_bits(2)));
                end
            end
            req_write: begin
                if (!store_open) begin
                    errors++;
                    $display("ERROR: write request for %h without a store", mem_req.addr);
                end else begin
                    check_req("write_req", req_write,
                              {last_store.tag, last_store.idx, last_store.offset},
                              last_store.size, mem_req.kind, mem_req.addr, mem_req.size);
                    check_line("write_data", last_store.data, mem_req.data);
                    back_mem[ln] = write_bytes(back_mem[ln], mem_req.addr[2:0], mem_req.size,
                                               mem_req.data);
                    store_open = 1'b0;
                end
            end
            req_writeback: begin
                check_req("writeback_req", req_writeback, {ln, 3'b000}, double_size,
                          mem_req.kind, mem_req.addr, mem_req.size);
                check_line("writeback_data", arch_mem[ln], mem_req.data);
                back_mem[ln] = mem_req.data;
            end
            default: begin
                errors++;
                $display("ERROR: request with an unknown kind at %h", mem_req.addr);
            end
        endcase
    endtask

    // one clock, driven at the falling edge and sampled just before the rising edge
    task automatic do_cycle(input proc_access_t wr_acc, input proc_access_t rd_acc);
        logic [12:0] ln;
        @(negedge clock);
        if (busy) begin
            wr_acc.en = 1'b0;
            rd_acc.en = 1'b0;
        end
        // stores wait for an empty queue and for pending fills of their line
        if (mem_req.valid || pend_rd[{wr_acc.tag, wr_acc.idx}] != 0) begin
            wr_acc.en = 1'b0;
        end
        proc_wr = wr_acc;
        proc_rd = rd_acc;
        fill    = '0;
        if (!busy && fill_line.size() > 0 && cycle_no >= fill_due[0]) begin
            ln         = fill_line.pop_front();
            fill_due.delete(0);
            fill.en    = 1'b1;
            fill.tag   = ln[12:5];
            fill.idx   = ln[4:0];
            fill.data  = back_mem[ln];
            pend_rd[ln]--;
        end
        mem_ready = rand_bits(2) != 0;
        #4;
        wr_issued = wr_acc.en;
        rd_hit    = 1'b0;
        if (wr_acc.en) begin
            ln = {wr_acc.tag, wr_acc.idx};
            arch_mem[ln] = write_bytes(arch_mem[ln], wr_acc.offset, wr_acc.size, wr_acc.data);
            last_store = wr_acc;
            store_open = 1'b1;
        end
        if (rd_acc.en) begin
            ln = {rd_acc.tag, rd_acc.idx};
            if (rd_valid) begin
                rd_hit = 1'b1;
                check_line("load_hit", read_bytes(arch_mem[ln], rd_acc.offset, rd_acc.size),
                           rd_data);
            end else begin
                miss_line.push_back(ln);
                miss_gnt.push_back(rd_acc.gnt);
                miss_size.push_back(rd_acc.size);
                pend_rd[ln]++;
            end
        end
        if (mem_req.valid && mem_ready) begin
            take_request();
        end
        cycle_no++;
    endtask

    task automatic start_test(input string name);
        test_name    = name;
        test_checks0 = checks;
        test_errors0 = errors;
    endtask

    task automatic end_test();
        $display("test %s: %0d checks, %0d errors", test_name, checks - test_checks0,
                 errors - test_errors0);
    endtask

    task automatic reset_test();
        proc_access_t ld;
        start_test("reset_state");
        ld      = '0;
        ld.en   = 1'b1;
        ld.tag  = tag_pool[0];
        ld.idx  = 5'd3;
        ld.size = double_size;
        ld.gnt  = 8'h01;
        checks += 2;
        if (busy) begin
            errors++;
            $display("ERROR: busy is high after reset");
        end
        if (mem_req.valid) begin
            errors++;
            $display("ERROR: memory request valid after reset");
        end
        // all valid bits are clear, so the first load must miss
        do_cycle('0, ld);
        checks++;
        if (rd_hit) begin
            errors++;
            $display("ERROR: load hit in the cache right after reset");
        end
        end_test();
    endtask

    task automatic store_load_test();
        proc_access_t ld;
        proc_access_t st;
        int           n;
        start_test("store_then_load");
        ld        = '0;
        ld.en     = 1'b1;
        ld.tag    = tag_pool[1];
        ld.idx    = 5'd9;
        ld.offset = 3'd4;
        ld.size   = word_size;
        ld.gnt    = 8'h04;
        st        = ld;
        st.gnt    = '0;
        st.data   = 64'h0000_0000_a1b2_c3d4;
        // bring the line in through a miss and its fill
        n = 0;
        rd_hit = 1'b0;
        while (!rd_hit && n < cycle_limit) begin
            do_cycle('0, ld);
            n++;
        end
        if (!rd_hit) begin
            errors++;
            $display("ERROR: timeout, the line never arrived in the cache");
        end
        n = 0;
        wr_issued = 1'b0;
        while (!wr_issued && n < cycle_limit) begin
            do_cycle(st, '0);
            n++;
        end
        if (!wr_issued) begin
            errors++;
            $display("ERROR: timeout, the store could never be issued");
        end
        do_cycle('0, ld);
        if (!rd_hit) begin
            errors++;
            $display("ERROR: load after a store to a cached line missed");
        end
        // whole line load covers the bytes the store left alone
        ld.offset = 3'd0;
        ld.size   = double_size;
        do_cycle('0, ld);
        if (!rd_hit) begin
            errors++;
            $display("ERROR: line load after a store to a cached line missed");
        end
        end_test();
    endtask

    task automatic random_test(input int n);
        start_test("random_traffic");
        for (int i = 0; i < n; i++) begin
            do_cycle(random_access(1'b1), random_access(1'b0));
        end
        end_test();
    endtask

    task automatic drain_test();
        int n;
        start_test("drain");
        n = 0;
        while ((mem_req.valid || fill_line.size() > 0 || miss_line.size() > 0)
               && n < cycle_limit) begin
            do_cycle('0, '0);
            n++;
        end
        if (mem_req.valid || fill_line.size() > 0 || miss_line.size() > 0) begin
            errors++;
            $display("ERROR: timeout, requests or fills still pending after drain");
        end
        end_test();
    endtask

    initial begin
        lfsr       = 16'd51649;
        clock      = 1'b0;
        reset      = 1'b1;
        proc_wr    = '0;
        proc_rd    = '0;
        fill       = '0;
        mem_ready  = 1'b0;
        last_store = '0;
        store_open = 1'b0;
        wr_issued  = 1'b0;
        rd_hit     = 1'b0;
        cycle_no   = 0;
        checks     = 0;
        errors     = 0;
        test_name  = "";
        for (int i = 0; i < num_mem_lines; i++) begin
            arch_mem[i] = init_line(13'(i));
            back_mem[i] = arch_mem[i];
            pend_rd[i]  = 0;
        end
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        reset_test();
        store_load_test();
        random_test(3000);
        drain_test();
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/dmem_properties.sv
/* dmem_properties: port assertions on the data-memory top level,
   bound into dmem_top */
`default_nettype none

module dmem_properties (
    input logic                   clock,
    input logic                   reset,
    input dmem_pkg::proc_access_t proc_wr,
    input dmem_pkg::proc_access_t proc_rd,
    input logic                   rd_valid,
    input dmem_pkg::mem_req_t     mem_req,
    input logic                   mem_ready,
    input logic                   busy,
    input dmem_pkg::mem_req_t     wb_req,
    input dmem_pkg::mem_req_t     wr_req,
    input dmem_pkg::mem_req_t     rd_req
);
    import dmem_pkg::*;

    // strobed requests not yet taken by memory
    int held;

    always_ff @(posedge clock) begin
        if (reset) begin
            held <= 0;
        end else begin
            held <= held + int'(wb_req.valid) + int'(wr_req.valid) + int'(rd_req.valid)
                    - int'(mem_req.valid && mem_ready);
        end
    end

    assert property (@(posedge clock) reset |=> !busy && !mem_req.valid)
        else $error("busy or request valid directly after reset");
    assert property (@(posedge clock) disable iff (reset)
        mem_req.valid && !mem_ready |=> $stable(mem_req))
        else $error("memory request changed while held by back-pressure");
    assert property (@(posedge clock) disable iff (reset) rd_valid |-> proc_rd.en)
        else $error("load result without a load");
    assert property (@(posedge clock) disable iff (reset) held <= queue_depth)
        else $error("request queue overflow");
    assert property (@(posedge clock) disable iff (reset) mem_req.valid == (held != 0))
        else $error("port valid does not match the queued strobes");
    assert property (@(posedge clock) disable iff (reset) busy |-> !proc_wr.en && !proc_rd.en)
        else $error("access presented while busy");

endmodule

`default_nettype wire

//--- verilog/dmem_top.sv
/* dmem_top: data-memory subsystem, the data cache feeding its
   outgoing requests through a queue onto one memory port */
`default_nettype none

module dmem_top (
    input  logic                   clock,
    input  logic                   reset,
    input  dmem_pkg::proc_access_t proc_wr,
    input  dmem_pkg::proc_access_t proc_rd,
    input  dmem_pkg::mem_fill_t    fill,
    output dmem_pkg::line_data_t   rd_data,
    output logic                   rd_valid,
    output dmem_pkg::mem_req_t     mem_req,
    input  logic                   mem_ready,
    output logic                   busy
);
    import dmem_pkg::*;

    // one-cycle request strobes from the cache
    mem_req_t wb_req;
    mem_req_t wr_req;
    mem_req_t rd_req;

    dcache_store u_dcache_store (
        .clock    (clock),
        .reset    (reset),
        .proc_wr  (proc_wr),
        .proc_rd  (proc_rd),
        .fill     (fill),
        .rd_data  (rd_data),
        .rd_valid (rd_valid),
        .wb_req   (wb_req),
        .wr_req   (wr_req),
        .rd_req   (rd_req)
    );

    mem_req_queue u_mem_req_queue (
        .clock     (clock),
        .reset     (reset),
        .wb_req    (wb_req),
        .wr_req    (wr_req),
        .rd_req    (rd_req),
        .mem_req   (mem_req),
        .mem_ready (mem_ready),
        .busy      (busy)
    );

endmodule

`default_nettype wire

//--- verilog/mem_req_queue.sv
/* mem_req_queue: circular request queue that takes up to three strobes per cycle
   in fixed priority and hands them one at a time to the memory port */
`default_nettype none

module mem_req_queue (
    input  logic               clock,
    input  logic               reset,
    input  dmem_pkg::mem_req_t wb_req,
    input  dmem_pkg::mem_req_t wr_req,
    input  dmem_pkg::mem_req_t rd_req,
    output dmem_pkg::mem_req_t mem_req,
    input  logic               mem_ready,
    output logic               busy
);
    import dmem_pkg::*;

    mem_req_t   entries [queue_depth];
    mem_req_t   in_req [req_sources];
    queue_ptr_t push_slot [req_sources];
    queue_ptr_t head;
    queue_ptr_t tail;
    queue_ptr_t tail_next;
    queue_cnt_t count;
    queue_cnt_t push_count;
    queue_cnt_t free_slots;
    logic       pop;

    // priority order writeback, write, read
    always_comb begin
        in_req[0] = wb_req;
        in_req[1] = wr_req;
        in_req[2] = rd_req;
    end

    // valid strobes take consecutive slots from the tail
    always_comb begin
        tail_next  = tail;
        push_count = '0;
        for (int k = 0; k < req_sources; k++) begin
            push_slot[k] = tail_next;
            if (in_req[k].valid) begin
                tail_next  = tail_next + 1'b1;
                push_count = push_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int k = 0; k < req_sources; k++) begin
            if (in_req[k].valid) begin
                entries[push_slot[k]] <= in_req[k];
            end
        end
    end

    assign pop = mem_req.valid && mem_ready;

    // pointers wrap on their own since depth is a power of two
    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            tail  <= tail_next;
            count <= count + push_count - queue_cnt_t'(pop);
            if (pop) begin
                head <= head + 1'b1;
            end
        end
    end

    // head entry held until memory takes it
    always_comb begin
        mem_req       = entries[head];
        mem_req.valid = (count != '0);
    end

    // room must remain for a full cycle of strobes
    assign free_slots = queue_cnt_t'(queue_depth) - count;
    assign busy       = free_slots < queue_cnt_t'(req_sources);

endmodule

`default_nettype wire

//--- dcache/dcache_store.sv
/* dcache_store: direct-mapped write-back, no-write-allocate data cache with a
   two-entry victim buffer, resolving store, load and fill in one cycle */
`default_nettype none

module dcache_store (
    input  logic                   clock,
    input  logic                   reset,
    input  dmem_pkg::proc_access_t proc_wr,
    input  dmem_pkg::proc_access_t proc_rd,
    input  dmem_pkg::mem_fill_t    fill,
    output dmem_pkg::line_data_t   rd_data,
    output logic                   rd_valid,
    output dmem_pkg::mem_req_t     wb_req,
    output dmem_pkg::mem_req_t     wr_req,
    output dmem_pkg::mem_req_t     rd_req
);
    import dmem_pkg::*;

    typedef struct packed {
        line_data_t [num_lines-1:0]      data;
        line_tag_t  [num_lines-1:0]      tag;
        logic       [num_lines-1:0]      valid;
        logic       [num_lines-1:0]      dirty;
        line_data_t [victim_entries-1:0] vic_data;
        line_tag_t  [victim_entries-1:0] vic_tag;
        line_idx_t  [victim_entries-1:0] vic_idx;
        logic       [victim_entries-1:0] vic_valid;
        logic       [victim_entries-1:0] vic_dirty;
        // victim entry replaced by the next eviction
        logic                            lru;
    } cache_state_t;

    cache_state_t st_q;
    cache_state_t st_wr;
    cache_state_t st_rd;
    cache_state_t st_fill;

    logic                      wr_hit;
    logic [victim_entries-1:0] wr_vmatch;
    logic                      wr_vsel;
    logic                      rd_hit;
    logic [victim_entries-1:0] rd_vmatch;
    logic                      rd_vsel;
    logic [victim_entries-1:0] fill_vmatch;
    logic                      fill_conflict;

    function automatic line_data_t size_mask(mem_size_e size);
        case (size)
            byte_size: return 64'h0000_0000_0000_00ff;
            half_size: return 64'h0000_0000_0000_ffff;
            word_size: return 64'h0000_0000_ffff_ffff;
            default:   return '1;
        endcase
    endfunction

    // byte lanes of the store replace those of the line
    function automatic line_data_t merge_store(line_data_t line, proc_access_t acc);
        line_data_t mask;
        mask = size_mask(acc.size) << {acc.offset, 3'b000};
        return (line & ~mask) | ((acc.data << {acc.offset, 3'b000}) & mask);
    endfunction

    function automatic line_data_t extract(line_data_t line, proc_access_t acc);
        return (line >> {acc.offset, 3'b000}) & size_mask(acc.size);
    endfunction

    function automatic logic main_hit(cache_state_t st, line_tag_t tag, line_idx_t idx);
        return st.valid[idx] && st.tag[idx] == tag;
    endfunction

    function automatic logic [victim_entries-1:0] vic_match(cache_state_t st,
                                                            line_tag_t    tag,
                                                            line_idx_t    idx);
        logic [victim_entries-1:0] m;
        for (int i = 0; i < victim_entries; i++) begin
            m[i] = st.vic_valid[i] && st.vic_tag[i] == tag && st.vic_idx[i] == idx;
        end
        return m;
    endfunction

    // victim entry sel trades places with main slot idx
    function automatic cache_state_t swap_in(cache_state_t st, line_idx_t idx, logic sel);
        cache_state_t nxt;
        nxt = st;
        nxt.data[idx]      = st.vic_data[sel];
        nxt.tag[idx]       = st.vic_tag[sel];
        nxt.valid[idx]     = 1'b1;
        nxt.dirty[idx]     = st.vic_dirty[sel];
        nxt.vic_data[sel]  = st.data[idx];
        nxt.vic_tag[sel]   = st.tag[idx];
        nxt.vic_idx[sel]   = idx;
        nxt.vic_valid[sel] = st.valid[idx];
        nxt.vic_dirty[sel] = st.dirty[idx];
        nxt.lru            = ~sel;
        return nxt;
    endfunction

    assign wr_hit    = main_hit(st_q, proc_wr.tag, proc_wr.idx);
    assign wr_vmatch = vic_match(st_q, proc_wr.tag, proc_wr.idx);
    // with two entries the upper match bit is the entry index
    assign wr_vsel   = wr_vmatch[1];

    assign rd_hit    = main_hit(st_wr, proc_rd.tag, proc_rd.idx);
    assign rd_vmatch = vic_match(st_wr, proc_rd.tag, proc_rd.idx);
    assign rd_vsel   = rd_vmatch[1];

    // line already held in the main slot or in either victim entry
    assign fill_vmatch   = vic_match(st_rd, fill.tag, fill.idx);
    assign fill_conflict = main_hit(st_rd, fill.tag, fill.idx) | fill_vmatch[0] | fill_vmatch[1];

    // store stage
    always_comb begin
        st_wr  = st_q;
        wr_req = '0;
        if (proc_wr.en) begin
            if (wr_hit || wr_vmatch != '0) begin
                if (!wr_hit) begin
                    st_wr = swap_in(st_q, proc_wr.idx, wr_vsel);
                end
                st_wr.data[proc_wr.idx]  = merge_store(st_wr.data[proc_wr.idx], proc_wr);
                st_wr.dirty[proc_wr.idx] = 1'b1;
            end else begin
                // no write allocate so the store goes straight to memory
                wr_req.valid = 1'b1;
                wr_req.kind  = req_write;
                wr_req.addr  = {proc_wr.tag, proc_wr.idx, proc_wr.offset};
                wr_req.data  = proc_wr.data;
                wr_req.size  = proc_wr.size;
            end
        end
    end

    // load stage sees this cycle's store
    always_comb begin
        st_rd    = st_wr;
        rd_data  = '0;
        rd_valid = 1'b0;
        rd_req   = '0;
        if (proc_rd.en) begin
            if (rd_hit) begin
                rd_data  = extract(st_wr.data[proc_rd.idx], proc_rd);
                rd_valid = 1'b1;
            end else if (rd_vmatch != '0) begin
                rd_data  = extract(st_wr.vic_data[rd_vsel], proc_rd);
                rd_valid = 1'b1;
                st_rd    = swap_in(st_wr, proc_rd.idx, rd_vsel);
            end else begin
                rd_req.valid = 1'b1;
                rd_req.kind  = req_read;
                rd_req.addr  = {proc_rd.tag, proc_rd.idx, 3'b000};
                rd_req.size  = proc_rd.size;
                rd_req.gnt   = proc_rd.gnt;
            end
        end
    end

    // fill stage is last in the chain
    always_comb begin
        st_fill = st_rd;
        wb_req  = '0;
        if (fill.en && !fill_conflict) begin
            if (st_rd.valid[fill.idx]) begin
                // lru victim leaves the cache and is written back if dirty
                if (st_rd.vic_valid[st_rd.lru] && st_rd.vic_dirty[st_rd.lru]) begin
                    wb_req.valid = 1'b1;
                    wb_req.kind  = req_writeback;
                    wb_req.addr  = {st_rd.vic_tag[st_rd.lru], st_rd.vic_idx[st_rd.lru], 3'b000};
                    wb_req.data  = st_rd.vic_data[st_rd.lru];
                    wb_req.size  = double_size;
                end
                st_fill.vic_data[st_rd.lru]  = st_rd.data[fill.idx];
                st_fill.vic_tag[st_rd.lru]   = st_rd.tag[fill.idx];
                st_fill.vic_idx[st_rd.lru]   = fill.idx;
                st_fill.vic_valid[st_rd.lru] = 1'b1;
                st_fill.vic_dirty[st_rd.lru] = st_rd.dirty[fill.idx];
                st_fill.lru                  = ~st_rd.lru;
            end
            st_fill.data[fill.idx]  = fill.data;
            st_fill.tag[fill.idx]   = fill.tag;
            st_fill.valid[fill.idx] = 1'b1;
            st_fill.dirty[fill.idx] = 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            st_q.valid     <= '0;
            st_q.dirty     <= '0;
            st_q.vic_valid <= '0;
            st_q.vic_dirty <= '0;
            st_q.lru       <= 1'b0;
        end else begin
            st_q <= st_fill;
        end
    end

endmodule

`default_nettype wire

//--- common/dmem_pkg.sv
/* dmem_pkg: shared types of the data-memory subsystem, covering address fields,
   access sizes, request kinds and the port bundles */
`default_nettype none

package dmem_pkg;

    localparam int lsq_size       = 8;
    localparam int num_lines      = 32;
    localparam int victim_entries = 2;
    localparam int queue_depth    = 4;
    localparam int queue_ptr_bits = $clog2(queue_depth);
    // writeback, write and read strobes per cycle
    localparam int req_sources    = 3;

    typedef logic [63:0]                    line_data_t;
    typedef logic [7:0]                     line_tag_t;
    typedef logic [$clog2(num_lines)-1:0]   line_idx_t;
    typedef logic [2:0]                     byte_off_t;
    // tag, index, offset from msb down
    typedef logic [15:0]                    mem_addr_t;
    typedef logic [lsq_size-1:0]            lsq_gnt_t;
    typedef logic [queue_ptr_bits-1:0]      queue_ptr_t;
    typedef logic [queue_ptr_bits:0]        queue_cnt_t;

    typedef enum logic [1:0] {
        byte_size,
        half_size,
        word_size,
        double_size
    } mem_size_e;

    typedef enum logic [1:0] {
        req_writeback,
        req_write,
        req_read
    } req_kind_e;

    // stores leave gnt at zero, loads leave data at zero
    typedef struct packed {
        logic       en;
        line_tag_t  tag;
        line_idx_t  idx;
        byte_off_t  offset;
        line_data_t data;
        mem_size_e  size;
        lsq_gnt_t   gnt;
    } proc_access_t;

    typedef struct packed {
        logic       en;
        line_tag_t  tag;
        line_idx_t  idx;
        line_data_t data;
    } mem_fill_t;

    typedef struct packed {
        logic       valid;
        req_kind_e  kind;
        mem_addr_t  addr;
        line_data_t data;
        mem_size_e  size;
        lsq_gnt_t   gnt;
    } mem_req_t;

endpackage

`default_nettype wire
